//--- motorPkg.sv
package motorPkg;

    // clocks of the 10 MHz system clock
    typedef logic [11:0] pwmLen_t;
    // on-time amounts, carried remainders and window counters
    typedef logic [15:0] posSum_t;
    typedef logic [3:0]  step_t;
    typedef logic [24:0] windowCount_t;

    typedef struct packed {
        pwmLen_t pwmLenWant;
        pwmLen_t pwmMinMask;
    } pwmConfig_t;

    typedef struct packed {
        windowCount_t count;
        logic         lastFirst;
        logic         lastSecond;
        step_t        step;
    } windowMarks_t;

    typedef struct packed {
        posSum_t accWant;
        posSum_t accReal;
    } phaseStatus_t;

    // commutation steps on which a phase looks at its peers
    localparam step_t STEP_PEER_FIRST  = 4'd6;
    localparam step_t STEP_PEER_SECOND = 4'd11;
    localparam int    STEP_COUNT       = 12;

    // register map, byte offsets of 32-bit words
    localparam logic [7:0] REG_CONFIG     = 8'h00;
    localparam logic [7:0] REG_WINDOW_LEN = 8'h04;
    localparam logic [7:0] REG_PL_LEN_A   = 8'h08;
    localparam logic [7:0] REG_PL_LEN_B   = 8'h0C;
    localparam logic [7:0] REG_PL_LEN_C   = 8'h10;
    localparam logic [7:0] REG_STATUS_A   = 8'h14;
    localparam logic [7:0] REG_STATUS_B   = 8'h18;
    localparam logic [7:0] REG_STATUS_C   = 8'h1C;
    localparam logic [7:0] REG_STEP       = 8'h20;

endpackage

//--- windowSequencer.sv
`timescale 1ns/100ps

module windowSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  motorPkg::windowCount_t windowLen,
    output motorPkg::windowMarks_t marks,
    output motorPkg::step_t        step
);

    import motorPkg::*;

    windowCount_t count;
    windowCount_t lastIndex;
    logic         wrap;

    assign lastIndex = windowLen - windowCount_t'(1);

    // also wrap if windowLen was lowered below the running count
    assign wrap = (count >= lastIndex);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            step  <= '0;
        end else if (wrap) begin
            count <= '0;
            if (step == step_t'(STEP_COUNT - 1)) begin
                step <= '0;
            end else begin
                step <= step + step_t'(1);
            end
        end else begin
            count <= count + windowCount_t'(1);
        end
    end

    // the two flags mark the last two cycles of the window
    always_comb begin
        marks.count      = count;
        marks.lastFirst  = (count == lastIndex);
        marks.lastSecond = (count == windowLen - windowCount_t'(2));
        marks.step       = step;
    end

endmodule

//--- pwmGenerator.sv
`timescale 1ns/100ps

module pwmGenerator (
    input  logic                   clk,
    input  logic                   rst,
    input  motorPkg::pwmConfig_t   cfg,
    input  motorPkg::windowMarks_t marks,
    input  motorPkg::posSum_t      plLen,
    input  motorPkg::posSum_t      peerFirst,
    input  motorPkg::posSum_t      peerSecond,
    output motorPkg::posSum_t      posSum,
    output motorPkg::phaseStatus_t status,
    output logic                   pwm
);

    import motorPkg::*;

    pwmLen_t periodCnt;
    logic    reload;
    logic    reloadDelayed;
    logic    accReload;

    posSum_t remain;
    posSum_t onCnt;
    posSum_t minOnTime;
    logic    less;

    posSum_t accWant;
    posSum_t accReal;

    // period restarts at window end, at its own end, or when idle
    assign reload = marks.lastFirst | (periodCnt == pwmLen_t'(1)) | (plLen == '0);

    always_ff @(posedge clk) begin
        if (rst || reload) begin
            periodCnt <= cfg.pwmLenWant;
        end else begin
            periodCnt <= periodCnt - pwmLen_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reloadDelayed <= 1'b0;
        end else begin
            reloadDelayed <= reload;
        end
    end

    // first cycle of a new period
    assign accReload = reloadDelayed & ~reload;

    assign posSum    = remain + plLen;
    assign minOnTime = posSum_t'(cfg.pwmMinMask);

    // a peer with less pending also holds this phase back
    always_comb begin
        less = (posSum < minOnTime);
        if (marks.step == STEP_PEER_FIRST) begin
            if (peerFirst < posSum) begin
                less = 1'b1;
            end
        end else if (marks.step == STEP_PEER_SECOND) begin
            if (peerSecond < posSum) begin
                less = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            remain <= '0;
            onCnt  <= '0;
        end else if (accReload) begin
            if (less) begin
                // too short for now, carry the whole sum over
                remain <= posSum;
                onCnt  <= '0;
            end else begin
                remain <= '0;
                onCnt  <= posSum;
            end
        end else if (onCnt != '0) begin
            onCnt <= onCnt - posSum_t'(1);
        end
    end

    assign pwm = (onCnt != '0);

    // per-window statistics, handed over on lastSecond
    always_ff @(posedge clk) begin
        if (rst) begin
            accWant <= '0;
            accReal <= '0;
            status  <= '0;
        end else if (marks.lastSecond) begin
            status.accWant <= accWant;
            status.accReal <= accReal;
            accWant        <= '0;
            accReal        <= '0;
        end else begin
            if (accReload) begin
                accWant <= accWant + plLen;
            end
            if (pwm) begin
                accReal <= accReal + posSum_t'(1);
            end
        end
    end

endmodule

//--- motorRegs.sv
`timescale 1ns/100ps

module motorRegs #(
    parameter int AXI_ADDR_WIDTH = 6
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  motorPkg::phaseStatus_t    statusA,
    input  motorPkg::phaseStatus_t    statusB,
    input  motorPkg::phaseStatus_t    statusC,
    input  motorPkg::step_t           step,
    output motorPkg::pwmConfig_t      cfg,
    output motorPkg::windowCount_t    windowLen,
    output motorPkg::posSum_t         plLenA,
    output motorPkg::posSum_t         plLenB,
    output motorPkg::posSum_t         plLenC
);

    import motorPkg::*;

    logic        idle;
    logic        writeGo;
    logic        readGo;
    logic        writeFire;
    logic        readFire;
    logic [31:0] readWord;
    logic [31:0] writeWord;

    // register contents as seen on the bus, unmapped reads give zero
    function automatic logic [31:0] wordAt(input logic [AXI_ADDR_WIDTH-1:0] addr);
        case (addr)
            REG_CONFIG:     wordAt = {4'd0, cfg.pwmMinMask, 4'd0, cfg.pwmLenWant};
            REG_WINDOW_LEN: wordAt = {7'd0, windowLen};
            REG_PL_LEN_A:   wordAt = {16'd0, plLenA};
            REG_PL_LEN_B:   wordAt = {16'd0, plLenB};
            REG_PL_LEN_C:   wordAt = {16'd0, plLenC};
            REG_STATUS_A:   wordAt = statusA;
            REG_STATUS_B:   wordAt = statusB;
            REG_STATUS_C:   wordAt = statusC;
            REG_STEP:       wordAt = {28'd0, step};
            default:        wordAt = '0;
        endcase
    endfunction

    function automatic logic [31:0] mergeBytes(
        input logic [31:0] oldWord,
        input logic [31:0] newWord,
        input logic [3:0]  strb
    );
        logic [31:0] merged;
        merged = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return merged;
    endfunction

    always_comb begin
        readWord  = wordAt(araddr);
        writeWord = mergeBytes(wordAt(awaddr), wdata, wstrb);
    end

    // a pending response blocks any new transfer
    assign idle    = ~bvalid & ~rvalid & ~awready & ~arready;
    assign writeGo = idle & awvalid & wvalid;
    assign readGo  = idle & arvalid & ~writeGo;

    assign writeFire = awready & awvalid & wready & wvalid;
    assign readFire  = arready & arvalid;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= writeGo;
            wready  <= writeGo;
            arready <= readGo;
            if (writeFire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (readFire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read data is captured once and held until rready
    always_ff @(posedge clk) begin
        if (readFire) begin
            rdata <= readWord;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg       <= '0;
            windowLen <= windowCount_t'(4095);
            plLenA    <= '0;
            plLenB    <= '0;
            plLenC    <= '0;
        end else if (writeFire) begin
            case (awaddr)
                REG_CONFIG: begin
                    cfg.pwmLenWant <= writeWord[11:0];
                    cfg.pwmMinMask <= writeWord[27:16];
                end
                REG_WINDOW_LEN: windowLen <= writeWord[24:0];
                REG_PL_LEN_A:   plLenA    <= writeWord[15:0];
                REG_PL_LEN_B:   plLenB    <= writeWord[15:0];
                REG_PL_LEN_C:   plLenC    <= writeWord[15:0];
                default: ;
            endcase
        end
    end

endmodule

//--- motorPwmTop.sv
`timescale 1ns/100ps

module motorPwmTop #(
    parameter int AXI_ADDR_WIDTH = 6
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output logic                      pwmA,
    output logic                      pwmB,
    output logic                      pwmC
);

    import motorPkg::*;

    pwmConfig_t   cfg;
    windowCount_t windowLen;
    posSum_t      plLenA, plLenB, plLenC;
    windowMarks_t marks;
    step_t        step;
    phaseStatus_t statusA, statusB, statusC;
    posSum_t      posSumA, posSumB, posSumC;

    motorRegs #(.AXI_ADDR_WIDTH(AXI_ADDR_WIDTH)) regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .statusA(statusA), .statusB(statusB), .statusC(statusC), .step(step),
        .cfg(cfg), .windowLen(windowLen),
        .plLenA(plLenA), .plLenB(plLenB), .plLenC(plLenC)
    );

    windowSequencer seq (
        .clk(clk), .rst(rst), .windowLen(windowLen), .marks(marks), .step(step)
    );

    // peers rotate so each phase sees the next two in order
    pwmGenerator genA (
        .clk(clk), .rst(rst), .cfg(cfg), .marks(marks), .plLen(plLenA),
        .peerFirst(posSumB), .peerSecond(posSumC),
        .posSum(posSumA), .status(statusA), .pwm(pwmA)
    );

    pwmGenerator genB (
        .clk(clk), .rst(rst), .cfg(cfg), .marks(marks), .plLen(plLenB),
        .peerFirst(posSumC), .peerSecond(posSumA),
        .posSum(posSumB), .status(statusB), .pwm(pwmB)
    );

    pwmGenerator genC (
        .clk(clk), .rst(rst), .cfg(cfg), .marks(marks), .plLen(plLenC),
        .peerFirst(posSumA), .peerSecond(posSumB),
        .posSum(posSumC), .status(statusC), .pwm(pwmC)
    );

endmodule

//--- tbMotorPwm.sv
`timescale 1ns/100ps

module tbMotorPwm;

    import motorPkg::*;

    localparam int ADDR_W         = 6;
    localparam int MAX_WINDOW_LEN = 400;
    // windows run by the tests, with room for draining long carried pulses
    localparam int TOTAL_WINDOWS  = 40;
    localparam int WATCH_NS       = (TOTAL_WINDOWS * MAX_WINDOW_LEN + 2000) * 100;
    localparam int AXI_WAIT_LIMIT = 64;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] awaddr;
    logic [ADDR_W-1:0] araddr;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;
    logic              arvalid, arready, rvalid, rready;
    logic [31:0]       wdata;
    logic [31:0]       rdata;
    logic [3:0]        wstrb;
    logic [1:0]        bresp;
    logic [1:0]        rresp;
    logic              pwmA, pwmB, pwmC;

    logic [31:0] seed;
    int          errorCount;
    logic        pwmCheckOn;
    logic        watchIdleC;
    int          idleHighCycles;

    // model copy of the configuration, the sequencer and three generators
    pwmConfig_t   mCfg;
    windowCount_t mWinLen;
    posSum_t      mPlLen [3];
    windowCount_t mCount;
    step_t        mStep;
    int           mWindows;
    pwmLen_t      mPeriod [3];
    logic         mReloadD [3];
    posSum_t      mRemain [3];
    posSum_t      mOn [3];
    posSum_t      mAccWant [3];
    posSum_t      mAccReal [3];
    phaseStatus_t mStatus [3];

    // model values at the cycle a read is accepted
    step_t        snapStep;
    phaseStatus_t snapStatus [3];

    motorPwmTop #(.AXI_ADDR_WIDTH(ADDR_W)) dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int unsigned randIn(input int unsigned lo, input int unsigned hi);
        logic [31:0] r;
        r = lcgNext();
        return lo + ((r >> 8) % (hi - lo + 1));
    endfunction

    // bits of each register that hold a field
    function automatic logic [31:0] fieldMask(input logic [ADDR_W-1:0] addr);
        case (addr)
            6'h00:               return 32'h0FFF_0FFF;
            6'h04:               return 32'h01FF_FFFF;
            6'h08, 6'h0C, 6'h10: return 32'h0000_FFFF;
            default:             return 32'h0000_0000;
        endcase
    endfunction

    function automatic void applyWrite(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        case (addr)
            6'h00: begin
                mCfg.pwmLenWant = data[11:0];
                mCfg.pwmMinMask = data[27:16];
            end
            6'h04:   mWinLen   = data[24:0];
            6'h08:   mPlLen[0] = data[15:0];
            6'h0C:   mPlLen[1] = data[15:0];
            6'h10:   mPlLen[2] = data[15:0];
            default: ;
        endcase
    endfunction

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkPwm(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH %0t: pwm A/B/C is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic checkStatus(input phaseStatus_t got, input phaseStatus_t exp,
                               input string what);
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH %0t: %s want/real %0d/%0d, expected %0d/%0d", $time, what,
                     got.accWant, got.accReal, exp.accWant, exp.accReal);
        end
    endtask

    task automatic axiWrite(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        int waited;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!(awready && wready) && waited < AXI_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= AXI_WAIT_LIMIT) begin
            errorCount++;
            $display("write to address %h was never accepted", addr);
        end
        @(posedge clk);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        applyWrite(addr, data);
        waited = 0;
        @(negedge clk);
        while (!bvalid && waited < AXI_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= AXI_WAIT_LIMIT) begin
            errorCount++;
            $display("write to address %h got no write response", addr);
        end
        checkWord({30'd0, bresp}, 32'd0, "bresp");
        // hold off the response for a few cycles
        repeat (randIn(0, 3)) @(posedge clk);
        @(posedge clk);
        #10;
        bready = 1'b1;
        @(posedge clk);
        #10;
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
        int waited;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!arready && waited < AXI_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= AXI_WAIT_LIMIT) begin
            errorCount++;
            $display("read of address %h was never accepted", addr);
        end
        snapStep   = mStep;
        snapStatus = mStatus;
        @(posedge clk);
        #10;
        arvalid = 1'b0;
        waited  = 0;
        @(negedge clk);
        while (!rvalid && waited < AXI_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= AXI_WAIT_LIMIT) begin
            errorCount++;
            $display("read of address %h returned no data", addr);
        end
        data = rdata;
        checkWord({30'd0, rresp}, 32'd0, "rresp");
        repeat (randIn(0, 3)) @(posedge clk);
        @(posedge clk);
        #10;
        rready = 1'b1;
        @(posedge clk);
        #10;
        rready = 1'b0;
    endtask

    // waits for the next window start, then reads step and the three statistics
    task automatic checkWindow();
        int          target;
        logic [31:0] data;
        target = mWindows + 1;
        while (mWindows < target) begin
            @(posedge clk);
            #10;
        end
        repeat (randIn(0, 40)) begin
            @(posedge clk);
            #10;
        end
        axiRead(6'h20, data);
        checkWord(data, {28'd0, snapStep}, "step");
        for (int p = 0; p < 3; p++) begin
            axiRead(6'(6'h14 + 4 * p), data);
            checkStatus(phaseStatus_t'(data), snapStatus[p], $sformatf("status %0d", p));
        end
    endtask

    always @(posedge clk) begin : cycleModel
        posSum_t sum [3];
        logic    lastFirst;
        logic    lastSecond;
        logic    reload;
        logic    accReload;
        logic    less;
        if (rst) begin
            mCount = '0;
            mStep  = '0;
            for (int p = 0; p < 3; p++) begin
                mPeriod[p]  = mCfg.pwmLenWant;
                mReloadD[p] = 1'b0;
                mRemain[p]  = '0;
                mOn[p]      = '0;
                mAccWant[p] = '0;
                mAccReal[p] = '0;
                mStatus[p]  = '0;
            end
        end else begin
            lastFirst  = (mCount == mWinLen - 25'd1);
            lastSecond = (mCount == mWinLen - 25'd2);
            for (int p = 0; p < 3; p++) begin
                sum[p] = mRemain[p] + mPlLen[p];
            end
            for (int p = 0; p < 3; p++) begin
                reload    = lastFirst || (mPeriod[p] == 12'd1) || (mPlLen[p] == 16'd0);
                accReload = mReloadD[p] && !reload;
                less      = (sum[p] < {4'd0, mCfg.pwmMinMask});
                // peers are the next two phases in A, B, C order
                if (mStep == 4'd6 && sum[(p + 1) % 3] < sum[p]) begin
                    less = 1'b1;
                end
                if (mStep == 4'd11 && sum[(p + 2) % 3] < sum[p]) begin
                    less = 1'b1;
                end
                if (lastSecond) begin
                    mStatus[p]  = {mAccWant[p], mAccReal[p]};
                    mAccWant[p] = '0;
                    mAccReal[p] = '0;
                end else begin
                    if (accReload) begin
                        mAccWant[p] = mAccWant[p] + mPlLen[p];
                    end
                    if (mOn[p] != 16'd0) begin
                        mAccReal[p] = mAccReal[p] + 16'd1;
                    end
                end
                if (accReload) begin
                    mRemain[p] = less ? sum[p] : 16'd0;
                    mOn[p]     = less ? 16'd0 : sum[p];
                end else if (mOn[p] != 16'd0) begin
                    mOn[p] = mOn[p] - 16'd1;
                end
                mPeriod[p]  = reload ? mCfg.pwmLenWant : mPeriod[p] - 12'd1;
                mReloadD[p] = reload;
            end
            if (mCount >= mWinLen - 25'd1) begin
                mCount = '0;
                mStep  = (mStep == 4'd11) ? 4'd0 : mStep + 4'd1;
                mWindows++;
            end else begin
                mCount = mCount + 25'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (pwmCheckOn) begin
            checkPwm({pwmA, pwmB, pwmC}, {mOn[0] != 16'd0, mOn[1] != 16'd0, mOn[2] != 16'd0});
            if (watchIdleC && pwmC) begin
                idleHighCycles++;
            end
        end
    end

    initial begin : watchdog
        #(WATCH_NS);
        $display("timeout: the run did not finish within %0d ns", WATCH_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] data;
        logic [31:0] written [5];
        int unsigned lenWant;
        seed           = 32'h5e68_639e;
        errorCount     = 0;
        pwmCheckOn     = 1'b0;
        watchIdleC     = 1'b0;
        idleHighCycles = 0;
        mWindows       = 0;
        rst            = 1'b1;
        awaddr         = '0;
        araddr         = '0;
        awvalid        = 1'b0;
        wvalid         = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        bready         = 1'b0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        mCfg           = '0;
        mWinLen        = 25'd4095;
        mPlLen         = '{16'd0, 16'd0, 16'd0};
        repeat (8) @(posedge clk);
        #10;
        rst        = 1'b0;
        pwmCheckOn = 1'b1;

        // register readback, masked to the field widths
        for (int i = 0; i < 5; i++) begin
            written[i] = lcgNext();
            axiWrite(6'(4 * i), written[i]);
        end
        axiWrite(6'h28, lcgNext());
        for (int i = 0; i < 5; i++) begin
            axiRead(6'(4 * i), data);
            checkWord(data, written[i] & fieldMask(6'(4 * i)), $sformatf("register %0d", i));
        end
        axiRead(6'h24, data);
        checkWord(data, 32'd0, "unmapped 0x24");
        axiRead(6'h3C, data);
        checkWord(data, 32'd0, "unmapped 0x3C");

        // random pulses over several windows, statistics and step each window
        for (int round = 0; round < 2; round++) begin
            lenWant = randIn(16, 200);
            axiWrite(6'h00, {4'd0, 12'(randIn(0, lenWant / 2)), 4'd0, 12'(lenWant)});
            axiWrite(6'h04, randIn(200, MAX_WINDOW_LEN));
            for (int p = 0; p < 3; p++) begin
                axiWrite(6'(6'h08 + 4 * p), randIn(0, lenWant));
            end
            repeat (7) checkWindow();
        end

        // small amounts carried until they reach the minimum, phase C idle
        axiWrite(6'h00, {4'd0, 12'd40, 4'd0, 12'd50});
        axiWrite(6'h04, 32'd300);
        axiWrite(6'h08, 32'd7);
        axiWrite(6'h0C, 32'd13);
        axiWrite(6'h10, 32'd0);
        checkWindow();
        while (mOn[2] != 16'd0) begin
            @(posedge clk);
            #10;
        end
        watchIdleC = 1'b1;
        repeat (3) checkWindow();
        watchIdleC = 1'b0;
        checkWord(32'(idleHighCycles), 32'd0, "pwmC high cycles with plLen 0");

        pwmCheckOn = 1'b0;
        $display("run complete, %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog.f
motorPkg.sv
windowSequencer.sv
pwmGenerator.sv
motorRegs.sv
motorPwmTop.sv
tbMotorPwm.sv

//--- runSim.sh
#!/bin/sh
# build and run the motor PWM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tbMotorPwm -f verilog.f -o simMotorPwm
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simMotorPwm > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
exit 1
